//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_split_join
FILELIST  := split_join.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# the simulator is rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- hdr_join.sv
`timescale 1ns/1ps
`default_nettype none

module hdr_join #(
   parameter int DATA_BYTES = split_join_pkg::data_bytes_c
) (
   input  wire                         axi4s_in,
   input  wire                         rst_n,
   input  wire                         enable,
   input  wire                         clear_mismatch,

   input  wire                         hdr_in_valid,
   output logic                        hdr_in_ready,
   input  wire  [DATA_BYTES*8-1:0]     hdr_in_data,
   input  wire  [DATA_BYTES-1:0]       hdr_in_keep,
   input  wire                         hdr_in_last,
   input  wire  split_join_pkg::tag_t  hdr_in_tag,

   input  wire                         fifo_valid,
   output logic                        fifo_ready,
   input  wire  [DATA_BYTES*8-1:0]     fifo_data,
   input  wire  [DATA_BYTES-1:0]       fifo_keep,
   input  wire                         fifo_last,
   input  wire  split_join_pkg::tag_t  fifo_tag,

   output logic                        j_valid,
   input  wire                         j_ready,
   output logic [DATA_BYTES*8-1:0]     j_data,
   output logic [DATA_BYTES-1:0]       j_keep,
   output logic                        j_last,
   output split_join_pkg::tag_t        j_tag,

   output logic                        sop_mismatch
);

   import split_join_pkg::*;

   join_state_e             state;
   logic                    hdr_first;
   tag_t                    first_tag;
   tag_t                    sop_tag;
   logic                    j_free;
   logic                    pyld_empty;
   logic                    hdr_fire;
   logic                    fifo_fire;
   logic                    mismatch_evt;
   logic                    j_load;
   logic [DATA_BYTES*8-1:0] j_data_nxt;
   logic [DATA_BYTES-1:0]   j_keep_nxt;
   logic                    j_last_nxt;
   tag_t                    j_tag_nxt;

   assign j_free     = !j_valid || j_ready;
   assign pyld_empty = (fifo_keep == '0) && fifo_last;
   assign hdr_fire   = hdr_in_valid && hdr_in_ready;
   assign fifo_fire  = fifo_valid && fifo_ready;

   // ---------------------------------------------------------------------
   // source selection
   // ---------------------------------------------------------------------
   always_comb begin
      hdr_in_ready = 1'b0;
      fifo_ready   = 1'b0;
      j_load       = 1'b0;
      j_data_nxt   = hdr_in_data;
      j_keep_nxt   = hdr_in_keep;
      j_last_nxt   = hdr_in_last;
      j_tag_nxt    = hdr_in_tag;
      case (state)
         join_hdr: begin
            // the last header word waits until its payload head can be seen.
            hdr_in_ready = j_free && (!hdr_in_last || fifo_valid);
            fifo_ready   = hdr_in_valid && hdr_in_last && j_free && pyld_empty;
            j_load       = hdr_fire;
            j_last_nxt   = hdr_in_last && pyld_empty;
         end
         join_pyld: begin
            fifo_ready = j_free;
            j_load     = fifo_valid && j_free && (fifo_keep != '0);
            j_data_nxt = fifo_data;
            j_keep_nxt = fifo_keep;
            j_last_nxt = fifo_last;
            j_tag_nxt  = fifo_tag;
         end
         join_pass: begin
            hdr_in_ready = j_free;
            j_load       = hdr_fire;
         end
         default: begin
         end
      endcase
   end

   // the payload head is checked against the first header word's tag.
   assign sop_tag      = hdr_first ? hdr_in_tag : first_tag;
   assign mismatch_evt = (state == join_hdr) && hdr_fire && hdr_in_last &&
                         (fifo_tag != sop_tag);

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         state        <= join_idle;
         hdr_first    <= 1'b1;
         j_valid      <= 1'b0;
         sop_mismatch <= 1'b0;
      end else begin
         case (state)
            join_idle: begin
               hdr_first <= 1'b1;
               if (hdr_in_valid) begin
                  state <= enable ? join_hdr : join_pass;
               end
            end
            join_hdr: begin
               if (hdr_fire) begin
                  hdr_first <= 1'b0;
                  if (hdr_in_last) begin
                     state <= pyld_empty ? join_idle : join_pyld;
                  end
               end
            end
            join_pyld: begin
               if (fifo_fire && fifo_last) begin
                  state <= join_idle;
               end
            end
            default: begin
               if (hdr_fire && hdr_in_last) begin
                  state <= join_idle;
               end
            end
         endcase
         if (j_load) begin
            j_valid <= 1'b1;
         end else if (j_ready) begin
            j_valid <= 1'b0;
         end
         // a new mismatch wins over a clear in the same cycle.
         if (mismatch_evt) begin
            sop_mismatch <= 1'b1;
         end else if (clear_mismatch) begin
            sop_mismatch <= 1'b0;
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (hdr_fire && hdr_first) begin
         first_tag <= hdr_in_tag;
      end
      if (j_load) begin
         j_data <= j_data_nxt;
         j_keep <= j_keep_nxt;
         j_last <= j_last_nxt;
         j_tag  <= j_tag_nxt;
      end
   end

endmodule

`default_nettype wire

//--- hdr_split.sv
`timescale 1ns/1ps
`default_nettype none

module hdr_split #(
   parameter int DATA_BYTES = split_join_pkg::data_bytes_c
) (
   input  wire                              axi4s_in,
   input  wire                              rst_n,
   input  wire  split_join_pkg::hdr_words_t hdr_words,

   input  wire                              in_valid,
   output logic                             in_ready,
   input  wire  [DATA_BYTES*8-1:0]          in_data,
   input  wire  [DATA_BYTES-1:0]            in_keep,
   input  wire                              in_last,
   input  wire  split_join_pkg::tag_t       in_tag,

   output logic                             hdr_out_valid,
   input  wire                              hdr_out_ready,
   output logic [DATA_BYTES*8-1:0]          hdr_out_data,
   output logic [DATA_BYTES-1:0]            hdr_out_keep,
   output logic                             hdr_out_last,
   output split_join_pkg::tag_t             hdr_out_tag,

   output logic                             pyld_valid,
   input  wire                              pyld_ready,
   output logic [DATA_BYTES*8-1:0]          pyld_data,
   output logic [DATA_BYTES-1:0]            pyld_keep,
   output logic                             pyld_last,
   output split_join_pkg::tag_t             pyld_tag,

   output logic                             enable
);

   import split_join_pkg::*;

   hdr_words_t cnt;
   logic       in_pkt;
   logic       mode_ok;
   logic       to_hdr;
   logic       empty_pyld;
   logic       hdr_end;
   logic       hdr_free;
   logic       pyld_free;
   logic       in_fire;
   logic       hdr_load;
   logic       pyld_load;

   // ---------------------------------------------------------------------
   // word routing
   // ---------------------------------------------------------------------
   assign hdr_free  = !hdr_out_valid || hdr_out_ready;
   assign pyld_free = !pyld_valid || pyld_ready;

   // the first word of a packet waits one cycle if the mode is about to change.
   assign mode_ok    = in_pkt || (enable == (hdr_words != '0));
   assign to_hdr     = !enable || (cnt < hdr_words);
   assign empty_pyld = enable && to_hdr && in_last;
   assign hdr_end    = in_last || (enable && (hdr_words_t'(cnt + 1'b1) == hdr_words));

   // a short packet needs room on both outputs, for its header and its marker.
   assign in_ready  = mode_ok && (to_hdr ? (hdr_free && (!empty_pyld || pyld_free))
                                         : pyld_free);
   assign in_fire   = in_valid && in_ready;
   assign hdr_load  = in_fire && to_hdr;
   assign pyld_load = in_fire && (!to_hdr || empty_pyld);

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         enable        <= 1'b0;
         in_pkt        <= 1'b0;
         cnt           <= '0;
         hdr_out_valid <= 1'b0;
         pyld_valid    <= 1'b0;
      end else begin
         if (!in_pkt) begin
            enable <= (hdr_words != '0);
         end
         if (in_fire) begin
            in_pkt <= !in_last;
            if (in_last) begin
               cnt <= '0;
            end else if (enable && to_hdr) begin
               cnt <= cnt + 1'b1;
            end
         end
         if (hdr_load) begin
            hdr_out_valid <= 1'b1;
         end else if (hdr_out_ready) begin
            hdr_out_valid <= 1'b0;
         end
         if (pyld_load) begin
            pyld_valid <= 1'b1;
         end else if (pyld_ready) begin
            pyld_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (hdr_load) begin
         hdr_out_data <= in_data;
         hdr_out_keep <= in_keep;
         hdr_out_last <= hdr_end;
         hdr_out_tag  <= in_tag;
      end
      // an empty payload is sent as one last word with no valid bytes.
      if (pyld_load) begin
         pyld_data <= in_data;
         pyld_keep <= empty_pyld ? '0 : in_keep;
         pyld_last <= in_last;
         pyld_tag  <= in_tag;
      end
   end

endmodule

`default_nettype wire

//--- pyld_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pyld_fifo #(
   parameter int DATA_BYTES = split_join_pkg::data_bytes_c,
   parameter int FIFO_DEPTH = 64
) (
   input  wire                         axi4s_in,
   input  wire                         rst_n,
   input  wire                         enable,

   input  wire                         wr_valid,
   output logic                        wr_ready,
   input  wire  [DATA_BYTES*8-1:0]     wr_data,
   input  wire  [DATA_BYTES-1:0]       wr_keep,
   input  wire                         wr_last,
   input  wire  split_join_pkg::tag_t  wr_tag,

   output logic                        rd_valid,
   input  wire                         rd_ready,
   output logic [DATA_BYTES*8-1:0]     rd_data,
   output logic [DATA_BYTES-1:0]       rd_keep,
   output logic                        rd_last,
   output split_join_pkg::tag_t        rd_tag
);

   import split_join_pkg::*;

   localparam int ADDR_W = $clog2(FIFO_DEPTH);
   localparam int WORD_W = DATA_BYTES * 9 + 1 + $bits(tag_t);

   logic [WORD_W-1:0] mem [FIFO_DEPTH];
   logic [ADDR_W:0]   wr_ptr;
   logic [ADDR_W:0]   rd_ptr;
   logic              empty;
   logic              full;
   logic              wr_fire;
   logic              rd_load;

   // pointers carry one extra bit to tell full from empty.
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   assign wr_ready = !full;
   assign wr_fire  = enable && wr_valid && !full;
   assign rd_load  = enable && !empty && (!rd_valid || rd_ready);

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         rd_valid <= 1'b0;
      end else if (!enable) begin
         // flush, which drops everything stored and the word at the read port.
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         rd_valid <= 1'b0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_load) begin
            rd_ptr   <= rd_ptr + 1'b1;
            rd_valid <= 1'b1;
         end else if (rd_ready) begin
            rd_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (wr_fire) begin
         mem[wr_ptr[ADDR_W-1:0]] <= {wr_tag, wr_last, wr_keep, wr_data};
      end
      if (rd_load) begin
         {rd_tag, rd_last, rd_keep, rd_data} <= mem[rd_ptr[ADDR_W-1:0]];
      end
   end

endmodule

`default_nettype wire

//--- split_join.f
split_join_pkg.sv
stream_pipe.sv
hdr_split.sv
pyld_fifo.sv
hdr_join.sv
split_join.sv
tb_split_join.sv

//--- split_join.sv
`timescale 1ns/1ps
`default_nettype none

module split_join #(
   parameter int DATA_BYTES = split_join_pkg::data_bytes_c,
   parameter int FIFO_DEPTH = 64
) (
   input  wire                              axi4s_in,
   input  wire                              rst_n,
   input  wire  split_join_pkg::hdr_words_t hdr_words,
   input  wire                              clear_mismatch,

   input  wire                              in_valid,
   output logic                             in_ready,
   input  wire  [DATA_BYTES*8-1:0]          in_data,
   input  wire  [DATA_BYTES-1:0]            in_keep,
   input  wire                              in_last,
   input  wire  split_join_pkg::tag_t       in_tag,

   output logic                             hdr_out_valid,
   input  wire                              hdr_out_ready,
   output logic [DATA_BYTES*8-1:0]          hdr_out_data,
   output logic [DATA_BYTES-1:0]            hdr_out_keep,
   output logic                             hdr_out_last,
   output split_join_pkg::tag_t             hdr_out_tag,

   input  wire                              hdr_in_valid,
   output logic                             hdr_in_ready,
   input  wire  [DATA_BYTES*8-1:0]          hdr_in_data,
   input  wire  [DATA_BYTES-1:0]            hdr_in_keep,
   input  wire                              hdr_in_last,
   input  wire  split_join_pkg::tag_t       hdr_in_tag,

   output logic                             out_valid,
   input  wire                              out_ready,
   output logic [DATA_BYTES*8-1:0]          out_data,
   output logic [DATA_BYTES-1:0]            out_keep,
   output logic                             out_last,
   output split_join_pkg::tag_t             out_tag,

   output logic                             sop_mismatch
);

   import split_join_pkg::*;

   logic                    p_valid, p_ready, p_last;
   logic [DATA_BYTES*8-1:0] p_data;
   logic [DATA_BYTES-1:0]   p_keep;
   tag_t                    p_tag;

   logic                    pyld_valid, pyld_ready, pyld_last;
   logic [DATA_BYTES*8-1:0] pyld_data;
   logic [DATA_BYTES-1:0]   pyld_keep;
   tag_t                    pyld_tag;

   logic                    fifo_valid, fifo_ready, fifo_last;
   logic [DATA_BYTES*8-1:0] fifo_data;
   logic [DATA_BYTES-1:0]   fifo_keep;
   tag_t                    fifo_tag;

   logic                    j_valid, j_ready, j_last;
   logic [DATA_BYTES*8-1:0] j_data;
   logic [DATA_BYTES-1:0]   j_keep;
   tag_t                    j_tag;

   logic                    enable;

   // ---------------------------------------------------------------------
   // ingress and split
   // ---------------------------------------------------------------------
   stream_pipe #(.DATA_BYTES(DATA_BYTES)) u_in_pipe (
      .axi4s_in, .rst_n,
      .s_valid(in_valid), .s_ready(in_ready), .s_data(in_data),
      .s_keep(in_keep), .s_last(in_last), .s_tag(in_tag),
      .m_valid(p_valid), .m_ready(p_ready), .m_data(p_data),
      .m_keep(p_keep), .m_last(p_last), .m_tag(p_tag)
   );

   hdr_split #(.DATA_BYTES(DATA_BYTES)) u_split (
      .axi4s_in, .rst_n, .hdr_words,
      .in_valid(p_valid), .in_ready(p_ready), .in_data(p_data),
      .in_keep(p_keep), .in_last(p_last), .in_tag(p_tag),
      .hdr_out_valid, .hdr_out_ready, .hdr_out_data,
      .hdr_out_keep, .hdr_out_last, .hdr_out_tag,
      .pyld_valid, .pyld_ready, .pyld_data, .pyld_keep, .pyld_last, .pyld_tag,
      .enable
   );

   // payloads wait here while the outside processes their headers.
   pyld_fifo #(.DATA_BYTES(DATA_BYTES), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .axi4s_in, .rst_n, .enable,
      .wr_valid(pyld_valid), .wr_ready(pyld_ready), .wr_data(pyld_data),
      .wr_keep(pyld_keep), .wr_last(pyld_last), .wr_tag(pyld_tag),
      .rd_valid(fifo_valid), .rd_ready(fifo_ready), .rd_data(fifo_data),
      .rd_keep(fifo_keep), .rd_last(fifo_last), .rd_tag(fifo_tag)
   );

   // ---------------------------------------------------------------------
   // join and egress
   // ---------------------------------------------------------------------
   hdr_join #(.DATA_BYTES(DATA_BYTES)) u_join (
      .axi4s_in, .rst_n, .enable, .clear_mismatch,
      .hdr_in_valid, .hdr_in_ready, .hdr_in_data,
      .hdr_in_keep, .hdr_in_last, .hdr_in_tag,
      .fifo_valid, .fifo_ready, .fifo_data, .fifo_keep, .fifo_last, .fifo_tag,
      .j_valid, .j_ready, .j_data, .j_keep, .j_last, .j_tag,
      .sop_mismatch
   );

   stream_pipe #(.DATA_BYTES(DATA_BYTES)) u_out_pipe (
      .axi4s_in, .rst_n,
      .s_valid(j_valid), .s_ready(j_ready), .s_data(j_data),
      .s_keep(j_keep), .s_last(j_last), .s_tag(j_tag),
      .m_valid(out_valid), .m_ready(out_ready), .m_data(out_data),
      .m_keep(out_keep), .m_last(out_last), .m_tag(out_tag)
   );

endmodule

`default_nettype wire

//--- split_join_pkg.sv
`default_nettype none

package split_join_pkg;

   // default number of bytes in one stream word.
   localparam int data_bytes_c = 8;

   // packet tag carried next to data, keep and last on every stream.
   typedef logic [3:0] tag_t;

   // header length, counted in whole stream words.
   typedef logic [7:0] hdr_words_t;

   // joiner sequencing.
   typedef enum logic [1:0] {
      join_idle,
      join_hdr,
      join_pyld,
      join_pass
   } join_state_e;

endpackage

`default_nettype wire

//--- stream_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module stream_pipe #(
   parameter int DATA_BYTES = split_join_pkg::data_bytes_c
) (
   input  wire                         axi4s_in,
   input  wire                         rst_n,

   input  wire                         s_valid,
   output logic                        s_ready,
   input  wire  [DATA_BYTES*8-1:0]     s_data,
   input  wire  [DATA_BYTES-1:0]       s_keep,
   input  wire                         s_last,
   input  wire  split_join_pkg::tag_t  s_tag,

   output logic                        m_valid,
   input  wire                         m_ready,
   output logic [DATA_BYTES*8-1:0]     m_data,
   output logic [DATA_BYTES-1:0]       m_keep,
   output logic                        m_last,
   output split_join_pkg::tag_t        m_tag
);

   import split_join_pkg::*;

   logic                    skid_valid;
   logic [DATA_BYTES*8-1:0] skid_data;
   logic [DATA_BYTES-1:0]   skid_keep;
   logic                    skid_last;
   tag_t                    skid_tag;
   logic                    m_load;

   // upstream ready comes straight from a flop, so no path crosses this stage.
   assign s_ready = !skid_valid;
   assign m_load  = m_ready || !m_valid;

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         m_valid    <= 1'b0;
         skid_valid <= 1'b0;
      end else if (m_load) begin
         m_valid    <= skid_valid || s_valid;
         skid_valid <= 1'b0;
      end else if (s_valid && s_ready) begin
         skid_valid <= 1'b1;
      end
   end

   // the skid register catches the word that arrives while the output stalls.
   always_ff @(posedge axi4s_in) begin
      if (m_load) begin
         m_data <= skid_valid ? skid_data : s_data;
         m_keep <= skid_valid ? skid_keep : s_keep;
         m_last <= skid_valid ? skid_last : s_last;
         m_tag  <= skid_valid ? skid_tag  : s_tag;
      end else if (s_valid && s_ready) begin
         skid_data <= s_data;
         skid_keep <= s_keep;
         skid_last <= s_last;
         skid_tag  <= s_tag;
      end
   end

endmodule

`default_nettype wire

//--- tb_split_join.sv
`timescale 1ns/1ps
`default_nettype none

module tb_split_join;

   import split_join_pkg::*;

   localparam int DB = data_bytes_c;
   localparam int DW = DB * 8;
   localparam int EDIT_NONE  = 0;
   localparam int EDIT_EXTRA = 1;
   localparam int EDIT_TAG   = 2;

   logic          axi4s_in, rst_n, clear_mismatch;
   hdr_words_t    hdr_words;
   logic          in_valid, in_ready, in_last;
   logic          hdr_out_valid, hdr_out_ready, hdr_out_last;
   logic          hdr_in_valid, hdr_in_ready, hdr_in_last;
   logic          out_valid, out_ready, out_last, sop_mismatch;
   logic [DW-1:0] in_data, hdr_out_data, hdr_in_data, out_data;
   logic [DB-1:0] in_keep, hdr_out_keep, hdr_in_keep, out_keep;
   tag_t          in_tag, hdr_out_tag, hdr_in_tag, out_tag;

   // stimulus, planned for all phases before reset is released.
   logic [DW-1:0] w_data [2048];
   logic [DB-1:0] w_keep [2048];
   int            pkt_start [256];
   int            pkt_len [256];
   int            pkt_edit [256];
   int            pkt_ph [256];
   tag_t          pkt_tag [256];
   string         ph_name [8];
   int            ph_hw [8];
   int            ph_first [8];
   int            ph_count [8];
   int            ph_accept [8];
   int            ph_return [8];
   int            ph_out [8];
   int            ph_clear [8];
   int            n_pkts, n_words, n_phases;
   int            cur_accept, cur_return, cur_out;
   logic [31:0]   gen_rng;
   int            cycles, cycle_limit, in_stalls, words_checked;
   int            value_errors, flag_errors, other_errors;
   logic          mismatch_expected;
   int            model_pkt;

   logic [DW-1:0] exp_data [$];
   logic [DB-1:0] exp_keep [$];
   logic          exp_last [$];
   tag_t          exp_tag [$];
   int            exp_pkt [$];

   // words held by the header processor model until it returns them.
   logic [DW-1:0] mq_data [$];
   logic [DB-1:0] mq_keep [$];
   logic          mq_last [$];
   tag_t          mq_tag [$];

   split_join #(.DATA_BYTES(DB), .FIFO_DEPTH(16)) u_split_join (.*);

   initial begin
      axi4s_in = 1'b0;
      forever #20 axi4s_in = ~axi4s_in;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [DW-1:0] extra_word(input int p);
      return {DB{8'ha5}} ^ DW'(p);
   endfunction

   function automatic void push_expected(input int p, input logic [DW-1:0] d,
                                         input logic [DB-1:0] k, input tag_t t);
      exp_pkt.push_back(p);
      exp_data.push_back(d);
      exp_keep.push_back(k);
      exp_last.push_back(1'b0);
      exp_tag.push_back(t);
   endfunction

   function automatic void push_model(input logic [DW-1:0] d, input logic [DB-1:0] k,
                                      input logic l, input tag_t t);
      mq_data.push_back(d);
      mq_keep.push_back(k);
      mq_last.push_back(l);
      mq_tag.push_back(t);
   endfunction

   // ------------------------------------------------------------------
   // reference model of one packet through split, header edit and join
   // ------------------------------------------------------------------
   function automatic void expect_packet(input int p);
      int   hw;
      int   n_hdr;
      int   w;
      int   base;
      tag_t t;
      hw    = ph_hw[pkt_ph[p]];
      base  = pkt_start[p];
      n_hdr = (hw == 0 || pkt_len[p] < hw) ? pkt_len[p] : hw;
      t     = (pkt_edit[p] == EDIT_TAG) ? ~pkt_tag[p] : pkt_tag[p];
      for (w = 0; w < n_hdr; w++) begin
         push_expected(p, ~w_data[base + w], w_keep[base + w], t);
      end
      if (pkt_edit[p] == EDIT_EXTRA) begin
         push_expected(p, extra_word(p), '1, t);
      end
      // payload words keep their data and their own tag.
      for (w = n_hdr; w < pkt_len[p]; w++) begin
         push_expected(p, w_data[base + w], w_keep[base + w], pkt_tag[p]);
      end
      exp_last[exp_last.size() - 1] = 1'b1;
   endfunction

   task automatic plan_phase(input string name, input int hw, input int count,
                             input int min_len, input int max_len, input int edit_every,
                             input int edit_kind, input int accept, input int ret,
                             input int out, input int clr);
      int i;
      int w;
      int p;
      ph_name[n_phases]   = name;
      ph_hw[n_phases]     = hw;
      ph_first[n_phases]  = n_pkts;
      ph_count[n_phases]  = count;
      ph_accept[n_phases] = accept;
      ph_return[n_phases] = ret;
      ph_out[n_phases]    = out;
      ph_clear[n_phases]  = clr;
      for (i = 0; i < count; i++) begin
         p = n_pkts;
         gen_rng = xorshift(gen_rng);
         pkt_len[p]   = min_len + int'(gen_rng[15:0]) % (max_len - min_len + 1);
         pkt_tag[p]   = gen_rng[19:16];
         pkt_edit[p]  = (edit_every > 0 && i % edit_every == edit_every - 1) ?
                        edit_kind : EDIT_NONE;
         pkt_ph[p]    = n_phases;
         pkt_start[p] = n_words;
         for (w = 0; w < pkt_len[p]; w++) begin
            gen_rng = xorshift(gen_rng);
            w_data[n_words] = DW'({gen_rng, xorshift(gen_rng ^ 32'(n_words))});
            w_keep[n_words] = (w == pkt_len[p] - 1) ? ({DB{1'b1}} >> gen_rng[26:24]) : '1;
            n_words++;
         end
         n_pkts++;
      end
      n_phases++;
   endtask

   task automatic send_packet(input int p);
      int   w;
      logic took;
      expect_packet(p);
      if (pkt_edit[p] == EDIT_TAG && ph_hw[pkt_ph[p]] != 0) begin
         mismatch_expected = 1'b1;
      end
      for (w = 0; w < pkt_len[p]; w++) begin
         in_valid = 1'b1;
         in_data  = w_data[pkt_start[p] + w];
         in_keep  = w_keep[pkt_start[p] + w];
         in_last  = (w == pkt_len[p] - 1);
         in_tag   = pkt_tag[p];
         took     = 1'b0;
         while (!took) begin
            @(negedge axi4s_in);
            took = in_ready;
            if (!took) begin
               in_stalls++;
            end
            @(posedge axi4s_in);
            #1;
         end
      end
      in_valid = 1'b0;
   endtask

   task automatic compare_word();
      int            p;
      string         name;
      logic [DW-1:0] d;
      logic [DB-1:0] k;
      logic          l;
      tag_t          t;
      if (exp_data.size() == 0) begin
         $display("ERROR: output word %h arrived with no packet outstanding", out_data);
         other_errors++;
      end else begin
         p    = exp_pkt.pop_front();
         d    = exp_data.pop_front();
         k    = exp_keep.pop_front();
         l    = exp_last.pop_front();
         t    = exp_tag.pop_front();
         name = ph_name[pkt_ph[p]];
         words_checked++;
         if (out_data !== d) begin
            $display("CHECK FAILED %s pkt %0d data: expected %h, actual %h", name, p, d, out_data);
            value_errors++;
         end
         if (out_keep !== k) begin
            $display("CHECK FAILED %s pkt %0d keep: expected %h, actual %h", name, p, k, out_keep);
            value_errors++;
         end
         if (out_last !== l) begin
            $display("CHECK FAILED %s pkt %0d last: expected %b, actual %b", name, p, l, out_last);
            value_errors++;
         end
         if (out_tag !== t) begin
            $display("CHECK FAILED %s pkt %0d tag: expected %h, actual %h", name, p, t, out_tag);
            value_errors++;
         end
      end
   endtask

   // ------------------------------------------------------------------
   // header processor model, accept side and return side
   // ------------------------------------------------------------------
   initial begin : hdr_accept
      logic [31:0] rng;
      logic        extra;
      tag_t        t;
      rng           = 32'hcb0c ^ 32'h0001_0000;
      hdr_out_ready = 1'b0;
      model_pkt     = 0;
      forever begin
         @(posedge axi4s_in);
         #1;
         rng = xorshift(rng);
         hdr_out_ready = (int'(rng[3:0]) >= cur_accept);
         @(negedge axi4s_in);
         if (hdr_out_valid && hdr_out_ready) begin
            t     = (pkt_edit[model_pkt] == EDIT_TAG) ? ~hdr_out_tag : hdr_out_tag;
            extra = hdr_out_last && (pkt_edit[model_pkt] == EDIT_EXTRA);
            push_model(~hdr_out_data, hdr_out_keep, hdr_out_last && !extra, t);
            if (extra) begin
               push_model(extra_word(model_pkt), '1, 1'b1, t);
            end
            if (hdr_out_last) begin
               model_pkt++;
            end
         end
      end
   end

   initial begin : hdr_return
      logic [31:0] rng;
      logic        took;
      rng          = 32'hcb0c ^ 32'h0002_0000;
      took         = 1'b0;
      hdr_in_valid = 1'b0;
      hdr_in_data  = '0;
      hdr_in_keep  = '0;
      hdr_in_last  = 1'b0;
      hdr_in_tag   = '0;
      forever begin
         @(posedge axi4s_in);
         #1;
         rng = xorshift(rng);
         if (took || !hdr_in_valid) begin
            hdr_in_valid = 1'b0;
            if (mq_data.size() != 0 && int'(rng[3:0]) >= cur_return) begin
               hdr_in_valid = 1'b1;
               hdr_in_data  = mq_data.pop_front();
               hdr_in_keep  = mq_keep.pop_front();
               hdr_in_last  = mq_last.pop_front();
               hdr_in_tag   = mq_tag.pop_front();
            end
         end
         @(negedge axi4s_in);
         took = hdr_in_valid && hdr_in_ready;
      end
   end

   // output checker, sampling mid-cycle where every output is settled.
   initial begin : out_check
      logic [31:0] rng;
      logic        mismatch_prev;
      rng           = 32'hcb0c ^ 32'h0003_0000;
      mismatch_prev = 1'b0;
      out_ready     = 1'b0;
      forever begin
         @(posedge axi4s_in);
         #1;
         rng = xorshift(rng);
         out_ready = (int'(rng[7:4]) >= cur_out);
         @(negedge axi4s_in);
         if (sop_mismatch && !mismatch_expected) begin
            $display("ERROR: sop_mismatch went high with no replaced tag outstanding");
            flag_errors++;
         end
         // the flag is sticky, so it may only fall after a clear pulse.
         if (mismatch_prev && !sop_mismatch && mismatch_expected) begin
            $display("ERROR: sop_mismatch fell before clear_mismatch was pulsed");
            flag_errors++;
         end
         mismatch_prev = sop_mismatch;
         if (out_valid && out_ready) begin
            compare_word();
         end
      end
   end

   initial begin : watchdog
      cycles = 0;
      while (cycles <= cycle_limit) begin
         @(posedge axi4s_in);
         cycles++;
      end
      $display("ERROR: run hung after %0d cycles with %0d output words still expected",
               cycles, exp_data.size());
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin : main_seq
      int ph;
      int p;
      int stalls_before;
      rst_n = 1'b0;
      clear_mismatch = 1'b0;
      hdr_words = '0;
      in_valid = 1'b0;
      in_data = '0;
      in_keep = '0;
      in_last = 1'b0;
      in_tag = '0;
      gen_rng = 32'hcb0c;
      mismatch_expected = 1'b0;
      plan_phase("split_join",   2, 40, 1, 12, 0, EDIT_NONE,  2, 3,  4, 0);
      plan_phase("short_pkt",    2,  8, 1,  2, 0, EDIT_NONE,  2, 2,  2, 0);
      plan_phase("hdr_extend",   2,  8, 1, 12, 2, EDIT_EXTRA, 2, 3,  3, 0);
      plan_phase("bypass",       0, 12, 1, 12, 0, EDIT_NONE,  3, 3,  3, 0);
      plan_phase("backpressure", 3, 30, 8, 12, 0, EDIT_NONE,  0, 13, 8, 0);
      plan_phase("mismatch",     2, 10, 1, 12, 5, EDIT_TAG,   2, 2,  2, 1);
      plan_phase("after_clear",  2, 10, 1, 12, 0, EDIT_NONE,  2, 2,  2, 0);
      cycle_limit = 40 * n_words;
      repeat (4) @(posedge axi4s_in);
      #1;
      rst_n = 1'b1;
      if (out_valid || hdr_out_valid || sop_mismatch) begin
         $display("ERROR: outputs not idle after reset");
         other_errors++;
      end
      for (ph = 0; ph < n_phases; ph++) begin
         hdr_words     = hdr_words_t'(ph_hw[ph]);
         cur_accept    = ph_accept[ph];
         cur_return    = ph_return[ph];
         cur_out       = ph_out[ph];
         stalls_before = in_stalls;
         for (p = ph_first[ph]; p < ph_first[ph] + ph_count[ph]; p++) begin
            send_packet(p);
         end
         while (exp_data.size() != 0) begin
            @(posedge axi4s_in);
            #1;
         end
         if (sop_mismatch !== mismatch_expected) begin
            $display("CHECK FAILED %s sop_mismatch: expected %b, actual %b",
                     ph_name[ph], mismatch_expected, sop_mismatch);
            flag_errors++;
         end
         if (ph_name[ph] == "backpressure" && in_stalls == stalls_before) begin
            $display("ERROR: input never stalled while the payload FIFO was loaded");
            other_errors++;
         end
         if (ph_clear[ph] != 0) begin
            clear_mismatch = 1'b1;
            @(posedge axi4s_in);
            #1;
            clear_mismatch    = 1'b0;
            mismatch_expected = 1'b0;
            @(negedge axi4s_in);
            if (sop_mismatch !== 1'b0) begin
               $display("CHECK FAILED %s clear: expected 0, actual %b", ph_name[ph], sop_mismatch);
               flag_errors++;
            end
            @(posedge axi4s_in);
            #1;
         end
      end
      $display("errors: %0d value, %0d flag, %0d other; %0d words checked",
               value_errors, flag_errors, other_errors, words_checked);
      if (value_errors + flag_errors + other_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
